//--- source/rvPkg.sv
`default_nettype none

package rvPkg;

    // machine word and memory sizes
    localparam int xlen = 32;
    localparam int imemDepth = 256;
    localparam int imemAddrBits = 8;
    localparam int dmemDepth = 256;
    localparam int dmemAddrBits = 8;

    // major opcodes of the supported subset
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // x10, the return value register
    localparam logic [4:0] a0Index = 5'd10;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluPassB
    } aluOpT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immFmtT;

    // writeback choices
    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4
    } resultSrcT;

endpackage

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic [6:0]       opcode,
    input  logic [2:0]       funct3,
    input  logic             funct7b5,
    input  logic             zero,
    output logic             regWrite,
    output logic             memAccess,
    output logic             memWrite,
    output logic             aluSrcA,
    output logic             aluSrcB,
    output rvPkg::aluOpT     aluOp,
    output rvPkg::immFmtT    immFmt,
    output rvPkg::resultSrcT resultSrc,
    output logic             pcTarget
);

    rvPkg::aluOpT functOp;
    logic         isBranch;
    logic         isJal;
    logic         branchTaken;

    // funct3 decode shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b010:  functOp = rvPkg::aluSlt;
            3'b110:  functOp = rvPkg::aluOr;
            3'b111:  functOp = rvPkg::aluAnd;
            default: functOp = rvPkg::aluAdd;
        endcase
    end

    always_comb begin
        regWrite  = 1'b0;
        memAccess = 1'b0;
        memWrite  = 1'b0;
        aluSrcA   = 1'b0;
        aluSrcB   = 1'b0;
        aluOp     = rvPkg::aluAdd;
        immFmt    = rvPkg::immI;
        resultSrc = rvPkg::resAlu;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        case (opcode)
            rvPkg::opOp: begin
                regWrite = 1'b1;
                // only funct7 bit 30 separates sub from add
                if (funct3 == 3'b000 && funct7b5) begin
                    aluOp = rvPkg::aluSub;
                end else begin
                    aluOp = functOp;
                end
            end
            rvPkg::opOpImm: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                aluOp    = functOp;
            end
            rvPkg::opLui: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                aluOp    = rvPkg::aluPassB;
                immFmt   = rvPkg::immU;
            end
            rvPkg::opLoad: begin
                regWrite  = 1'b1;
                memAccess = 1'b1;
                aluSrcB   = 1'b1;
                resultSrc = rvPkg::resMem;
            end
            rvPkg::opStore: begin
                memAccess = 1'b1;
                memWrite  = 1'b1;
                aluSrcB   = 1'b1;
                immFmt    = rvPkg::immS;
            end
            rvPkg::opBranch: begin
                aluOp    = rvPkg::aluSub;
                immFmt   = rvPkg::immB;
                isBranch = 1'b1;
            end
            rvPkg::opJal: begin
                regWrite  = 1'b1;
                aluSrcA   = 1'b1;
                aluSrcB   = 1'b1;
                immFmt    = rvPkg::immJ;
                resultSrc = rvPkg::resPcPlus4;
                isJal     = 1'b1;
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

    // beq and bne only
    assign branchTaken = (funct3 == 3'b000 && zero) || (funct3 == 3'b001 && !zero);
    assign pcTarget = (isBranch && branchTaken) || isJal;

endmodule

`default_nettype wire

//--- source/immExtend.sv
`timescale 1ns/1ps
`default_nettype none

module immExtend (
    input  logic [31:7]             immBits,
    input  rvPkg::immFmtT           immFmt,
    output logic [rvPkg::xlen-1:0]  immExt
);

    // immBits keeps the instruction bit numbering
    always_comb begin
        case (immFmt)
            rvPkg::immS: begin
                immExt = {{20{immBits[31]}}, immBits[31:25], immBits[11:7]};
            end
            rvPkg::immB: begin
                immExt = {{19{immBits[31]}}, immBits[31], immBits[7], immBits[30:25],
                          immBits[11:8], 1'b0};
            end
            rvPkg::immU: begin
                immExt = {immBits[31:12], 12'b0};
            end
            rvPkg::immJ: begin
                immExt = {{11{immBits[31]}}, immBits[31], immBits[19:12], immBits[20],
                          immBits[30:21], 1'b0};
            end
            default: begin
                immExt = {{20{immBits[31]}}, immBits[31:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    we,
    input  logic [4:0]              ra1,
    input  logic [4:0]              ra2,
    input  logic [4:0]              wa,
    input  logic [rvPkg::xlen-1:0]  wd,
    output logic [rvPkg::xlen-1:0]  rd1,
    output logic [rvPkg::xlen-1:0]  rd2,
    output logic [rvPkg::xlen-1:0]  a0
);

    logic [rvPkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            // x0 never written, so it stays at its reset zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    // return value always on show
    assign a0 = regs[rvPkg::a0Index];

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rvPkg::xlen-1:0]  rd1,
    input  logic [rvPkg::xlen-1:0]  rd2,
    input  logic [rvPkg::xlen-1:0]  pc,
    input  logic [rvPkg::xlen-1:0]  immExt,
    input  logic                    aluSrcA,
    input  logic                    aluSrcB,
    input  rvPkg::aluOpT            aluOp,
    output logic [rvPkg::xlen-1:0]  aluResult,
    output logic                    zero
);

    logic [rvPkg::xlen-1:0] srcA;
    logic [rvPkg::xlen-1:0] srcB;
    logic [rvPkg::xlen-1:0] diff;
    logic                   lessThan;

    assign srcA = aluSrcA ? pc : rd1;
    assign srcB = aluSrcB ? immExt : rd2;
    assign diff = srcA - srcB;
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluOp)
            rvPkg::aluSub:   aluResult = diff;
            rvPkg::aluAnd:   aluResult = srcA & srcB;
            rvPkg::aluOr:    aluResult = srcA | srcB;
            rvPkg::aluSlt:   aluResult = {{(rvPkg::xlen-1){1'b0}}, lessThan};
            rvPkg::aluPassB: aluResult = srcB;
            default:         aluResult = srcA + srcB;
        endcase
    end

    // branch compare flag
    assign zero = (diff == '0);

endmodule

`default_nettype wire

//--- source/instrMemory.sv
`timescale 1ns/1ps
`default_nettype none

module instrMemory (
    input  logic                            clk,
    input  logic                            progWe,
    input  logic [rvPkg::imemAddrBits-1:0]  progAddr,
    input  logic [rvPkg::xlen-1:0]          progData,
    input  logic [rvPkg::xlen-1:0]          pc,
    output logic [rvPkg::xlen-1:0]          instr
);

    logic [rvPkg::xlen-1:0] mem [rvPkg::imemDepth];

    // program load from outside
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // word fetch, byte offset and upper bits dropped
    assign instr = mem[pc[rvPkg::imemAddrBits+1:2]];

endmodule

`default_nettype wire

//--- source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [rvPkg::dmemAddrBits-1:0]  adr,
    input  logic [rvPkg::xlen-1:0]          datW,
    output logic [rvPkg::xlen-1:0]          datR,
    output logic                            ack
);

    logic [rvPkg::xlen-1:0] mem [rvPkg::dmemDepth];
    logic                   request;

    // new request seen, ack not yet given
    assign request = cyc && stb && !ack;

    // one wait state, ack drops the cycle after it was given
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= request;
        end
    end

    always_ff @(posedge clk) begin
        if (request) begin
            if (we) begin
                mem[adr] <= datW;
            end
            datR <= mem[adr];
        end
    end

endmodule

`default_nettype wire

//--- source/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            trigger,
    input  logic [rvPkg::xlen-1:0]          instr,
    input  logic [rvPkg::xlen-1:0]          datR,
    input  logic                            ack,
    output logic [rvPkg::xlen-1:0]          pc,
    output logic                            cyc,
    output logic                            stb,
    output logic                            we,
    output logic [rvPkg::dmemAddrBits-1:0]  adr,
    output logic [rvPkg::xlen-1:0]          datW,
    output logic [rvPkg::xlen-1:0]          a0
);

    logic                   regWrite;
    logic                   memAccess;
    logic                   memWrite;
    logic                   aluSrcA;
    logic                   aluSrcB;
    rvPkg::aluOpT           aluOp;
    rvPkg::immFmtT          immFmt;
    rvPkg::resultSrcT       resultSrc;
    logic                   pcTarget;
    logic                   zero;
    logic [rvPkg::xlen-1:0] immExt;
    logic [rvPkg::xlen-1:0] rd1;
    logic [rvPkg::xlen-1:0] rd2;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] result;
    logic [rvPkg::xlen-1:0] pcPlus4;
    logic [rvPkg::xlen-1:0] pcBranch;
    logic                   advance;

    controlUnit controlUnit_i (
        .opcode    (instr[6:0]),
        .funct3    (instr[14:12]),
        .funct7b5  (instr[30]),
        .zero      (zero),
        .regWrite  (regWrite),
        .memAccess (memAccess),
        .memWrite  (memWrite),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB),
        .aluOp     (aluOp),
        .immFmt    (immFmt),
        .resultSrc (resultSrc),
        .pcTarget  (pcTarget)
    );

    immExtend immExtend_i (
        .immBits (instr[31:7]),
        .immFmt  (immFmt),
        .immExt  (immExt)
    );

    regFile regFile_i (
        .clk  (clk),
        .rstN (rstN),
        .we   (regWrite && advance),
        .ra1  (instr[19:15]),
        .ra2  (instr[24:20]),
        .wa   (instr[11:7]),
        .wd   (result),
        .rd1  (rd1),
        .rd2  (rd2),
        .a0   (a0)
    );

    alu alu_i (
        .rd1       (rd1),
        .rd2       (rd2),
        .pc        (pc),
        .immExt    (immExt),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB),
        .aluOp     (aluOp),
        .aluResult (aluResult),
        .zero      (zero)
    );

    // wishbone request held until ack, then the pc moves on
    assign cyc  = memAccess && trigger;
    assign stb  = cyc;
    assign we   = memWrite && cyc;
    assign adr  = aluResult[rvPkg::dmemAddrBits+1:2];
    assign datW = rd2;

    // stall while the bus is busy, freeze while trigger is low
    assign advance = trigger && (!memAccess || ack);

    always_comb begin
        case (resultSrc)
            rvPkg::resMem:     result = datR;
            rvPkg::resPcPlus4: result = pcPlus4;
            default:           result = aluResult;
        endcase
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcBranch = pc + immExt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pcTarget ? pcBranch : pcPlus4;
        end
    end

endmodule

`default_nettype wire

//--- source/rvTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvTop (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            trigger,
    input  logic                            progWe,
    input  logic [rvPkg::imemAddrBits-1:0]  progAddr,
    input  logic [rvPkg::xlen-1:0]          progData,
    output logic [rvPkg::xlen-1:0]          a0,
    output logic [rvPkg::xlen-1:0]          pc
);

    logic [rvPkg::xlen-1:0]         instr;
    logic                           cyc;
    logic                           stb;
    logic                           we;
    logic [rvPkg::dmemAddrBits-1:0] adr;
    logic [rvPkg::xlen-1:0]         datW;
    logic [rvPkg::xlen-1:0]         datR;
    logic                           ack;

    rvCore core_i (
        .clk     (clk),
        .rstN    (rstN),
        .trigger (trigger),
        .instr   (instr),
        .datR    (datR),
        .ack     (ack),
        .pc      (pc),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datW    (datW),
        .a0      (a0)
    );

    instrMemory instrMemory_i (
        .clk      (clk),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr)
    );

    // data side over wishbone classic
    dataMemory dataMemory_i (
        .clk  (clk),
        .rstN (rstN),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .datW (datW),
        .datR (datR),
        .ack  (ack)
    );

endmodule

`default_nettype wire

//--- test/rvTopChecks.svh
`ifndef RV_TOP_CHECKS_SVH
`define RV_TOP_CHECKS_SVH

int valueErrors = 0;
int otherErrors = 0;

// failures without a value to compare
task automatic reportProblem(input string what);
    otherErrors++;
    $display("Error at %0t ns: %s", $time, what);
endtask

task automatic checkWord(
    input string                  name,
    input logic [rvPkg::xlen-1:0] expected,
    input logic [rvPkg::xlen-1:0] got
);
    if (got !== expected) begin
        valueErrors++;
        $display("Fail %s: expected 0x%08h, got 0x%08h", name, expected, got);
    end
endtask

// pc has to stay word aligned inside the instruction memory
task automatic checkPc(
    input string                  name,
    input logic [rvPkg::xlen-1:0] expected,
    input logic [rvPkg::xlen-1:0] got
);
    if (got[1:0] !== 2'b00 || (got >> (rvPkg::imemAddrBits + 2)) !== '0) begin
        reportProblem($sformatf("%s is not a word address inside instruction memory", name));
    end
    if (got !== expected) begin
        valueErrors++;
        $display("Fail %s: expected 0x%08h, got 0x%08h", name, expected, got);
    end
endtask

`endif

//--- test/rvTopTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvTopTb;

    logic                           clk;
    logic                           rstN;
    logic                           trigger;
    logic                           progWe;
    logic [rvPkg::imemAddrBits-1:0] progAddr;
    logic [rvPkg::xlen-1:0]         progData;
    logic [rvPkg::xlen-1:0]         a0;
    logic [rvPkg::xlen-1:0]         pc;

    // all programs as one flat word stream
    logic [31:0] stim [512];
    int          testCount;
    int          watchdogCycles;
    logic        stimReady = 1'b0;

    `include "rvTopChecks.svh"

    rvTop dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .trigger  (trigger),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .a0       (a0),
        .pc       (pc)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] fileWord(input int idx);
        return stim[idx[8:0]];
    endfunction

    task automatic applyReset();
        @(negedge clk);
        rstN    = 1'b0;
        trigger = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic loadProgram(input int first, input int words);
        for (int i = 0; i < words; i++) begin
            progWe   = 1'b1;
            progAddr = i[rvPkg::imemAddrBits-1:0];
            progData = fileWord(first + i);
            @(negedge clk);
        end
        progWe = 1'b0;
    endtask

    // run until pc sits still for 4 running cycles, one trigger pause on the way
    task automatic runToStop(input int pauseAt, input int pauseLen);
        logic [rvPkg::xlen-1:0] lastPc;
        logic [rvPkg::xlen-1:0] heldA0;
        int                     sameCount;
        int                     cycleCount;
        trigger    = 1'b1;
        lastPc     = pc;
        sameCount  = 0;
        cycleCount = 0;
        while (sameCount < 4) begin
            @(negedge clk);
            cycleCount++;
            if (pc === lastPc) begin
                sameCount++;
            end else begin
                sameCount = 0;
            end
            lastPc = pc;
            if (cycleCount == pauseAt) begin
                heldA0  = a0;
                trigger = 1'b0;
                // core frozen, pc and a0 must hold
                repeat (pauseLen) begin
                    @(negedge clk);
                    if (pc !== lastPc) begin
                        reportProblem("pc moved while trigger was low");
                    end
                    if (a0 !== heldA0) begin
                        reportProblem("a0 changed while trigger was low");
                    end
                end
                trigger = 1'b1;
            end
        end
        trigger = 1'b0;
    endtask

    initial begin
        int base;
        int words;
        clk      = 1'b0;
        rstN     = 1'b0;
        trigger  = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        void'($urandom(50855));
        $readmemh("test/rvProgInput.hex", stim);
        testCount = fileWord(0);
        if (testCount < 1) begin
            reportProblem("input file holds no tests");
            testCount = 0;
        end
        // budget for the watchdog, also catches a broken file layout
        base = 1;
        watchdogCycles = 100;
        for (int t = 0; t < testCount; t++) begin
            words = fileWord(base);
            if (words < 1 || base + words + 3 > 512) begin
                reportProblem($sformatf("test %0d has a bad word count", t));
                testCount = t;
                break;
            end
            watchdogCycles += words * 4 + 100;
            base += words + 3;
        end
        stimReady = 1'b1;
        base = 1;
        for (int t = 0; t < testCount; t++) begin
            words = fileWord(base);
            applyReset();
            checkWord("a0 after reset", '0, a0);
            loadProgram(base + 1, words);
            runToStop($urandom_range(8, 1), $urandom_range(5, 0));
            checkWord($sformatf("a0 of test %0d", t), fileWord(base + words + 1), a0);
            checkPc($sformatf("pc of test %0d", t), fileWord(base + words + 2), pc);
            base += words + 3;
        end
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (stimReady);
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: programs did not finish within %0d cycles", watchdogCycles);
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/rvProgInput.hex
// first word: number of tests
// per test: word count, program words, expected final a0, expected final pc
05
// arithmetic and logic, x0 write ignored
13
00C00093 00500113 FFD00593 002081B3 40208233 0020F2B3 0020E333 001123B3
0015A413 00F1F493 0070E013 00418533 00550533 00650533 00750533 00850533
00950533 00050533 0000006F
0000002C 00000048
// lui with positive and negative I immediates
0A
12345537 67850513 DEADC0B7 EEF08093 FFF00113 FF00F193 40A08533 00250533
00350533 0000006F
AB272756 00000024
// sw then lw over wishbone, first and last data word
11
05500093 CAFE0137 12310113 F9C00413 04000193 00102023 00202223 3E802E23
0031A423 00002203 00402283 3FC02303 0081A383 00520533 00650533 00750533
0000006F
CAFE0154 00000040
// beq and bne both ways, forward jal with link
10
00300093 00300113 00000513 00208463 00150513 00209463 00250513 00009463
00450513 00008463 00850513 00C002EF 01050513 02050513 00550533 0000006F
0000003A 0000003C
// countdown loop with memory traffic, paused mid-run
0A
00500093 00000513 10000193 00150533 00A1A023 0001A203 FFF08093 FE0098E3
00450533 0000006F
0000001E 00000024

//--- rvLite.f
+incdir+test
source/rvPkg.sv
source/controlUnit.sv
source/immExtend.sv
source/regFile.sv
source/alu.sv
source/instrMemory.sv
source/dataMemory.sv
source/rvCore.sv
source/rvTop.sv
test/rvTopTb.sv

//--- run.sh
#!/bin/sh
# build and run the rvLite testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module rvTopTb \
    -f rvLite.f -o rvTopSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rvTopSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
    exit 1
fi
exit 0
